/* sim/tb_uart_frame_top.sv */
// testbench for the uart string link
// host handshake models, a serial driver on the receive line and a
// serial monitor on the transmit line, with assertions on the responses
`timescale 1ns/1ps
`default_nettype none

module tb_uart_frame_top import uart_frame_pkg::*; ();

	localparam int        WAIT_LIMIT = 5000;
	localparam baud_div_t TEST_DIV   = 16'd8;

	logic      sys_clk;
	logic      sys_rst_n;
	logic      cfg_req;
	baud_div_t cfg_div;
	logic      cfg_ack;
	logic      tx_req;
	frame_t    tx_frame;
	logic      tx_ack;
	logic      rx_req;
	frame_t    rx_frame;
	logic      rx_ack;
	logic      uart_rx_line;
	logic      uart_tx_line;

	// reference state kept by the host and line models
	baud_div_t bit_div;
	char_t     exp_tx_q[$];
	int        mon_count;
	int        tx_expect_count;
	int        high_run;
	int        clk_count;
	logic      tx_in_flight;
	logic      rx_expected;
	frame_t    exp_rx;

	uart_frame_top uut (
		.sys_clk      (sys_clk),
		.sys_rst_n    (sys_rst_n),
		.cfg_req      (cfg_req),
		.cfg_div      (cfg_div),
		.cfg_ack      (cfg_ack),
		.tx_req       (tx_req),
		.tx_frame     (tx_frame),
		.tx_ack       (tx_ack),
		.rx_req       (rx_req),
		.rx_frame     (rx_frame),
		.rx_ack       (rx_ack),
		.uart_rx_line (uart_rx_line),
		.uart_tx_line (uart_tx_line)
	);

	always #10 sys_clk = ~sys_clk;

	task automatic fail_run();
		$display("Simulation finished: FAIL");
		$fatal(1);
	endtask

	task automatic report_mismatch(input string name, input logic [135:0] exp,
		input logic [135:0] got);
		$display("CHECK FAILED %s: expected %0h, got %0h", name, exp, got);
		fail_run();
	endtask

	task automatic report_problem(input string msg);
		$display("ERROR: %s", msg);
		fail_run();
	endtask

	function automatic char_t random_char();
		char_t c;
		c = char_t'($urandom);
		if (c == MARK_CHAR)
			c = 8'h41;
		return c;
	endfunction

	function automatic frame_t make_frame(input int len);
		frame_t f;
		f.len = len_t'(len);
		// characters past len are random too, they must never show up
		for (int i = 0; i < MAX_CHARS; i++)
			f.text[i] = random_char();
		return f;
	endfunction

	// first two picks are the empty and the full payload
	function automatic int pick_len(input int i);
		if (i == 0)
			return 0;
		if (i == 1)
			return MAX_CHARS;
		return $urandom_range(0, MAX_CHARS);
	endfunction

	// reference framing: two markers, len characters, two markers
	function automatic void frame_bytes(input frame_t f, ref char_t q[$]);
		q = {MARK_CHAR, MARK_CHAR};
		for (int i = 0; i < f.len; i++)
			q.push_back(f.text[i]);
		q.push_back(MARK_CHAR);
		q.push_back(MARK_CHAR);
	endfunction

	function automatic bit frame_matches(input frame_t got, input frame_t exp);
		if (got.len != exp.len)
			return 1'b0;
		for (int i = 0; i < MAX_CHARS; i++)
			if (i < exp.len && got.text[i] !== exp.text[i])
				return 1'b0;
		return 1'b1;
	endfunction

	// one byte with one idle bit after it, stop bit forced low on request
	task automatic drive_byte(input char_t b, input baud_div_t div, input bit bad_stop);
		uart_rx_line = 1'b0;
		repeat (div) @(negedge sys_clk);
		for (int i = 0; i < 8; i++) begin
			uart_rx_line = b[i];
			repeat (div) @(negedge sys_clk);
		end
		uart_rx_line = !bad_stop;
		repeat (div) @(negedge sys_clk);
		uart_rx_line = 1'b1;
		repeat (div) @(negedge sys_clk);
	endtask

	task automatic drive_bytes(input char_t q[$], input int bad_index);
		foreach (q[i])
			drive_byte(q[i], bit_div, i == bad_index);
	endtask

	task automatic write_divisor(input baud_div_t div);
		int cnt;
		cnt = 0;
		cfg_div = div;
		cfg_req = 1'b1;
		while (!cfg_ack) begin
			@(negedge sys_clk);
			cnt++;
			if (cnt > WAIT_LIMIT)
				report_problem("timeout waiting for cfg_ack to rise");
		end
		cfg_req = 1'b0;
		cnt = 0;
		while (cfg_ack) begin
			@(negedge sys_clk);
			cnt++;
			if (cnt > WAIT_LIMIT)
				report_problem("timeout waiting for cfg_ack to fall");
		end
		bit_div = div;
	endtask

	task automatic send_tx_frame(input frame_t f);
		char_t q[$];
		int    cnt;
		frame_bytes(f, q);
		foreach (q[i])
			exp_tx_q.push_back(q[i]);
		tx_expect_count += q.size();
		tx_frame = f;
		tx_req = 1'b1;
		tx_in_flight = 1'b1;
		cnt = 0;
		while (!tx_ack) begin
			@(negedge sys_clk);
			cnt++;
			if (cnt > WAIT_LIMIT)
				report_problem("timeout waiting for tx_ack to rise");
		end
		tx_in_flight = 1'b0;
		tx_req = 1'b0;
		cnt = 0;
		while (tx_ack) begin
			@(negedge sys_clk);
			cnt++;
			if (cnt > WAIT_LIMIT)
				report_problem("timeout waiting for tx_ack to fall");
		end
	endtask

	task automatic wait_rx_req();
		int cnt;
		cnt = 0;
		while (!rx_req) begin
			@(negedge sys_clk);
			cnt++;
			if (cnt > WAIT_LIMIT)
				report_problem("timeout waiting for rx_req to rise");
		end
		rx_expected = 1'b0;
	endtask

	task automatic ack_rx();
		int cnt;
		cnt = 0;
		rx_ack = 1'b1;
		while (rx_req) begin
			@(negedge sys_clk);
			cnt++;
			if (cnt > WAIT_LIMIT)
				report_problem("timeout waiting for rx_req to fall");
		end
		rx_ack = 1'b0;
		@(negedge sys_clk);
	endtask

	task automatic deliver_rx(input frame_t f);
		char_t q[$];
		exp_rx = f;
		rx_expected = 1'b1;
		frame_bytes(f, q);
		drive_bytes(q, -1);
		wait_rx_req();
		ack_rx();
	endtask

	// length of the current high run on the transmit line
	always @(negedge sys_clk) begin
		clk_count <= clk_count + 1;
		high_run <= uart_tx_line ? high_run + 1 : 0;
	end

	// serial monitor, decodes at mid-bit and compares with the reference
	always @(negedge sys_clk) begin
		char_t got;
		char_t want;
		if (sys_rst_n && !uart_tx_line) begin
			repeat (bit_div / 2) @(negedge sys_clk);
			assert (uart_tx_line == 1'b0)
				else report_mismatch("uart_tx_line start bit", 1'b0, uart_tx_line);
			for (int i = 0; i < 8; i++) begin
				repeat (bit_div) @(negedge sys_clk);
				got[i] = uart_tx_line;
			end
			repeat (bit_div) @(negedge sys_clk);
			assert (uart_tx_line == 1'b1)
				else report_mismatch("uart_tx_line stop bit", 1'b1, uart_tx_line);
			if (exp_tx_q.size() == 0) begin
				report_problem("byte on uart_tx_line with no frame requested");
			end else begin
				want = exp_tx_q.pop_front();
				assert (got == want)
					else report_mismatch("uart_tx_line byte", want, got);
				mon_count++;
			end
		end
	end

	assert property (@(posedge sys_clk) (clk_count > 0 && (!sys_rst_n || $rose(sys_rst_n)))
		|-> {uart_tx_line, tx_ack, rx_req, cfg_ack} == 4'b1000)
		else report_mismatch("{uart_tx_line,tx_ack,rx_req,cfg_ack}", 4'b1000,
			{uart_tx_line, tx_ack, rx_req, cfg_ack});

	assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		$fell(cfg_ack) |-> !$past(cfg_req))
		else report_problem("cfg_ack fell while cfg_req was still high");

	// divisor writes wait for the frame in flight
	assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		$rose(cfg_ack) |-> !tx_in_flight)
		else report_problem("cfg_ack rose before tx_ack during a transmit");

	assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		$rose(tx_ack) |-> mon_count == tx_expect_count)
		else report_mismatch("monitored byte count", tx_expect_count, mon_count);

	assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		$rose(tx_ack) |-> high_run >= bit_div)
		else report_problem("tx_ack rose before the last stop bit had ended");

	assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		$fell(tx_ack) |-> !$past(tx_req))
		else report_problem("tx_ack fell while tx_req was still high");

	assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		$rose(rx_req) |-> $past(rx_expected))
		else report_problem("rx_req rose without a valid frame on uart_rx_line");

	assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		rx_req |-> frame_matches(rx_frame, exp_rx))
		else report_mismatch("rx_frame", exp_rx, rx_frame);

	assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		$fell(rx_req) |-> $past(rx_ack))
		else report_problem("rx_req fell before rx_ack was raised");

	initial begin
		frame_t f;
		char_t  q[$];
		void'($urandom(32'h8229));
		sys_clk = 1'b0;
		sys_rst_n = 1'b0;
		cfg_req = 1'b0;
		cfg_div = DEFAULT_BAUD_DIV;
		tx_req = 1'b0;
		tx_frame = '0;
		rx_ack = 1'b0;
		uart_rx_line = 1'b1;
		bit_div = DEFAULT_BAUD_DIV;
		mon_count = 0;
		tx_expect_count = 0;
		high_run = 0;
		clk_count = 0;
		tx_in_flight = 1'b0;
		rx_expected = 1'b0;
		exp_rx = '0;
		repeat (16) @(negedge sys_clk);
		sys_rst_n = 1'b1;
		repeat (4) @(negedge sys_clk);

		write_divisor(TEST_DIV);
		for (int i = 0; i < 6; i++)
			send_tx_frame(make_frame(pick_len(i)));
		for (int i = 0; i < 6; i++)
			deliver_rx(make_frame(pick_len(i)));

		// lone marker followed by a letter
		q = {MARK_CHAR, MARK_CHAR, random_char(), random_char(), MARK_CHAR, 8'h51};
		drive_bytes(q, -1);
		deliver_rx(make_frame(pick_len(2)));

		// seventeen body characters
		q = {MARK_CHAR, MARK_CHAR};
		for (int i = 0; i <= MAX_CHARS; i++)
			q.push_back(random_char());
		drive_bytes(q, -1);
		deliver_rx(make_frame(pick_len(2)));

		// framing error on the closing marker
		frame_bytes(make_frame(pick_len(2)), q);
		drive_bytes(q, q.size() - 1);
		deliver_rx(make_frame(pick_len(2)));

		// first frame held unacknowledged while a second one arrives
		f = make_frame(pick_len(2));
		exp_rx = f;
		rx_expected = 1'b1;
		frame_bytes(f, q);
		drive_bytes(q, -1);
		wait_rx_req();
		frame_bytes(make_frame(pick_len(2)), q);
		drive_bytes(q, -1);
		ack_rx();
		repeat (40 * bit_div) @(negedge sys_clk);
		deliver_rx(make_frame(pick_len(2)));

		// divisor write issued in the middle of a transmit
		fork
			send_tx_frame(make_frame(MAX_CHARS));
			begin
				repeat (4 * TEST_DIV) @(negedge sys_clk);
				write_divisor(TEST_DIV);
			end
		join
		repeat (10) @(negedge sys_clk);

		$display("Simulation finished: PASS");
		$finish;
	end

endmodule

`default_nettype wire

/* source/frame_rx.sv */
// frame receiver
// hunts for a double marker, collects up to MAX_CHARS payload bytes
// and hands the frame to the host on a closing double marker
`timescale 1ns/1ps
`default_nettype none

module frame_rx import uart_frame_pkg::*; (
	input  logic   sys_clk,
	input  logic   sys_rst_n,
	input  logic   rx_byte_vld,
	input  char_t  rx_byte_data,
	input  logic   rx_byte_err,
	output logic   rx_req,
	output frame_t rx_frame,
	input  logic   rx_ack,
	output logic   rx_busy
);

	rx_state_e state;
	len_t      count;
	logic      good_byte;
	logic      is_mark;
	logic      body_full;

	assign good_byte = rx_byte_vld && !rx_byte_err;
	assign is_mark   = (rx_byte_data == MARK_CHAR);
	assign body_full = (count == len_t'(MAX_CHARS));
	assign rx_busy   = (state != RX_HUNT);

	// frame storage is written only in BODY and MARK4
	always_ff @(posedge sys_clk) begin
		if (state == RX_BODY && good_byte && !is_mark && !body_full)
			rx_frame.text[count[3:0]] <= rx_byte_data;
		if (state == RX_MARK4 && good_byte && is_mark)
			rx_frame.len <= count;
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state  <= RX_HUNT;
			count  <= '0;
			rx_req <= 1'b0;
		end else begin
			case (state)
				RX_HUNT: if (good_byte && is_mark)
					state <= RX_MARK2;
				RX_MARK2: if (rx_byte_vld) begin
					count <= '0;
					state <= (good_byte && is_mark) ? RX_BODY : RX_HUNT;
				end
				RX_BODY: if (rx_byte_vld) begin
					if (rx_byte_err)
						state <= RX_HUNT;
					else if (is_mark)
						state <= RX_MARK4;
					else if (body_full)
						state <= RX_HUNT;
					else
						count <= count + len_t'(1);
				end
				RX_MARK4: if (rx_byte_vld) begin
					if (good_byte && is_mark) begin
						state  <= RX_HOLD;
						rx_req <= 1'b1;
					end else begin
						state <= RX_HUNT;
					end
				end
				RX_HOLD: begin
					// incoming bytes are dropped until the host lets go
					if (rx_ack)
						rx_req <= 1'b0;
					if (!rx_req && !rx_ack)
						state <= RX_HUNT;
				end
				default: state <= RX_HUNT;
			endcase
		end
	end

	// the host acks only a frame on offer
	assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		$rose(rx_ack) |-> rx_req);

endmodule

`default_nettype wire

/* source/frame_tx.sv */
// frame transmitter
// sends a host string as two markers, the payload and two markers,
// one byte at a time through the uart bit engine
`timescale 1ns/1ps
`default_nettype none

module frame_tx import uart_frame_pkg::*; (
	input  logic   sys_clk,
	input  logic   sys_rst_n,
	input  logic   tx_req,
	input  frame_t tx_frame,
	output logic   tx_ack,
	output logic   tx_busy,
	output logic   byte_start,
	output char_t  byte_data,
	input  logic   byte_idle,
	input  logic   byte_done
);

	tx_state_e state;
	frame_t    frame_q;
	len_t      idx;
	logic      take_req;

	assign take_req = (state == TX_IDLE) && tx_req && byte_idle;
	assign tx_busy  = (state != TX_IDLE);

	always_ff @(posedge sys_clk) begin
		if (take_req)
			frame_q <= tx_frame;
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state      <= TX_IDLE;
			idx        <= '0;
			tx_ack     <= 1'b0;
			byte_start <= 1'b0;
			byte_data  <= '0;
		end else begin
			byte_start <= 1'b0;
			case (state)
				TX_IDLE: if (take_req) begin
					state      <= TX_MARK1;
					byte_start <= 1'b1;
					byte_data  <= MARK_CHAR;
				end
				TX_MARK1: if (byte_done) begin
					state      <= TX_MARK2;
					byte_start <= 1'b1;
					byte_data  <= MARK_CHAR;
				end
				TX_MARK2: if (byte_done) begin
					byte_start <= 1'b1;
					if (frame_q.len == '0) begin
						// empty payload, straight to the closing markers
						state     <= TX_MARK3;
						byte_data <= MARK_CHAR;
					end else begin
						state     <= TX_BODY;
						byte_data <= frame_q.text[0];
						idx       <= len_t'(1);
					end
				end
				TX_BODY: if (byte_done) begin
					byte_start <= 1'b1;
					if (idx == frame_q.len) begin
						state     <= TX_MARK3;
						byte_data <= MARK_CHAR;
					end else begin
						byte_data <= frame_q.text[idx[3:0]];
						idx       <= idx + len_t'(1);
					end
				end
				TX_MARK3: if (byte_done) begin
					state      <= TX_MARK4;
					byte_start <= 1'b1;
					byte_data  <= MARK_CHAR;
				end
				TX_MARK4: if (byte_done) begin
					state  <= TX_DONE;
					tx_ack <= 1'b1;
				end
				TX_DONE: if (!tx_req) begin
					state  <= TX_IDLE;
					tx_ack <= 1'b0;
				end
				default: state <= TX_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

/* source/uart_frame_pkg.sv */
// uart frame link shared definitions
// widths, marker character, reset divisor, host frame type and FSM encodings
`default_nettype none

package uart_frame_pkg;

	typedef logic [7:0] char_t;
	typedef logic [4:0] len_t;
	typedef logic [15:0] baud_div_t;

	localparam int MAX_CHARS = 16;
	localparam char_t MARK_CHAR = 8'h26;
	// 50 MHz clock at 115200 baud
	localparam baud_div_t DEFAULT_BAUD_DIV = 16'd434;

	// index 0 goes out first
	typedef char_t [MAX_CHARS-1:0] str_t;

	typedef struct packed {
		len_t len;
		str_t text;
	} frame_t;

	typedef enum logic [2:0] {
		TX_IDLE,
		TX_MARK1,
		TX_MARK2,
		TX_BODY,
		TX_MARK3,
		TX_MARK4,
		TX_DONE
	} tx_state_e;

	typedef enum logic [2:0] {
		RX_HUNT,
		RX_MARK2,
		RX_BODY,
		RX_MARK4,
		RX_HOLD
	} rx_state_e;

	typedef enum logic [1:0] {
		BIT_IDLE,
		BIT_START,
		BIT_DATA,
		BIT_STOP
	} bit_state_e;

endpackage

`default_nettype wire

/* source/uart_frame_top.sv */
// uart string link top level
// configuration block, transmit and receive framers and the two bit engines
`timescale 1ns/1ps
`default_nettype none

module uart_frame_top import uart_frame_pkg::*; (
	input  logic      sys_clk,
	input  logic      sys_rst_n,
	input  logic      cfg_req,
	input  baud_div_t cfg_div,
	output logic      cfg_ack,
	input  logic      tx_req,
	input  frame_t    tx_frame,
	output logic      tx_ack,
	output logic      rx_req,
	output frame_t    rx_frame,
	input  logic      rx_ack,
	input  logic      uart_rx_line,
	output logic      uart_tx_line
);

	baud_div_t baud_div;
	logic      tx_busy;
	logic      rx_busy;
	logic      link_busy;
	logic      byte_start;
	char_t     byte_data;
	logic      byte_idle;
	logic      byte_done;
	logic      rx_byte_vld;
	char_t     rx_byte_data;
	logic      rx_byte_err;

	// no divisor change while either direction is mid-frame
	assign link_busy = tx_busy | rx_busy;

	uart_link_cfg u_cfg (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.cfg_req   (cfg_req),
		.cfg_div   (cfg_div),
		.cfg_ack   (cfg_ack),
		.link_busy (link_busy),
		.baud_div  (baud_div)
	);

	frame_tx u_frame_tx (
		.sys_clk    (sys_clk),
		.sys_rst_n  (sys_rst_n),
		.tx_req     (tx_req),
		.tx_frame   (tx_frame),
		.tx_ack     (tx_ack),
		.tx_busy    (tx_busy),
		.byte_start (byte_start),
		.byte_data  (byte_data),
		.byte_idle  (byte_idle),
		.byte_done  (byte_done)
	);

	uart_tx u_uart_tx (
		.sys_clk      (sys_clk),
		.sys_rst_n    (sys_rst_n),
		.baud_div     (baud_div),
		.byte_start   (byte_start),
		.byte_data    (byte_data),
		.byte_idle    (byte_idle),
		.byte_done    (byte_done),
		.uart_tx_line (uart_tx_line)
	);

	uart_rx u_uart_rx (
		.sys_clk      (sys_clk),
		.sys_rst_n    (sys_rst_n),
		.baud_div     (baud_div),
		.uart_rx_line (uart_rx_line),
		.rx_byte_vld  (rx_byte_vld),
		.rx_byte_data (rx_byte_data),
		.rx_byte_err  (rx_byte_err)
	);

	frame_rx u_frame_rx (
		.sys_clk      (sys_clk),
		.sys_rst_n    (sys_rst_n),
		.rx_byte_vld  (rx_byte_vld),
		.rx_byte_data (rx_byte_data),
		.rx_byte_err  (rx_byte_err),
		.rx_req       (rx_req),
		.rx_frame     (rx_frame),
		.rx_ack       (rx_ack),
		.rx_busy      (rx_busy)
	);

endmodule

`default_nettype wire

/* source/uart_link_cfg.sv */
// uart link configuration
// holds the bit period divisor, loaded by a four-phase handshake
// a write waits until neither framer is busy
`timescale 1ns/1ps
`default_nettype none

module uart_link_cfg import uart_frame_pkg::*; (
	input  logic      sys_clk,
	input  logic      sys_rst_n,
	input  logic      cfg_req,
	input  baud_div_t cfg_div,
	output logic      cfg_ack,
	input  logic      link_busy,
	output baud_div_t baud_div
);

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			baud_div <= DEFAULT_BAUD_DIV;
			cfg_ack  <= 1'b0;
		end else if (!cfg_ack) begin
			// hold off until the current frame is out
			if (cfg_req && !link_busy) begin
				baud_div <= cfg_div;
				cfg_ack  <= 1'b1;
			end
		end else if (!cfg_req) begin
			cfg_ack <= 1'b0;
		end
	end

	// the host holds its request until the ack
	assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		$fell(cfg_req) |-> cfg_ack);

	// a zero divisor would stall both bit engines
	assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		$rose(cfg_ack) |-> baud_div != '0);

endmodule

`default_nettype wire

/* source/uart_rx.sv */
// uart receive bit engine
// start bit confirmed at half a bit, data sampled mid-bit,
// each byte reported at mid stop bit with its framing status
`timescale 1ns/1ps
`default_nettype none

module uart_rx import uart_frame_pkg::*; (
	input  logic      sys_clk,
	input  logic      sys_rst_n,
	input  baud_div_t baud_div,
	input  logic      uart_rx_line,
	output logic      rx_byte_vld,
	output char_t     rx_byte_data,
	output logic      rx_byte_err
);

	bit_state_e state;
	baud_div_t  baud_cnt;
	baud_div_t  half_div;
	logic [2:0] bit_cnt;
	// two sync stages plus one for edge detect
	logic [2:0] rx_sync;
	logic       rx_in;
	logic       rx_fall;
	logic       half_hit;
	logic       full_hit;

	assign rx_in    = rx_sync[1];
	assign rx_fall  = rx_sync[2] & ~rx_sync[1];
	assign half_div = baud_div >> 1;
	assign half_hit = (baud_cnt == half_div - 16'd1);
	assign full_hit = (baud_cnt == baud_div - 16'd1);

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n)
			rx_sync <= 3'b111;
		else
			rx_sync <= {rx_sync[1:0], uart_rx_line};
	end

	// lsb arrives first, so shift in from the top
	always_ff @(posedge sys_clk) begin
		if (state == BIT_DATA && full_hit)
			rx_byte_data <= {rx_in, rx_byte_data[7:1]};
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state       <= BIT_IDLE;
			baud_cnt    <= '0;
			bit_cnt     <= '0;
			rx_byte_vld <= 1'b0;
			rx_byte_err <= 1'b0;
		end else begin
			rx_byte_vld <= 1'b0;
			case (state)
				BIT_IDLE: begin
					baud_cnt <= '0;
					if (rx_fall)
						state <= BIT_START;
				end
				BIT_START: if (half_hit) begin
					baud_cnt <= '0;
					bit_cnt  <= '0;
					// line back high means a glitch
					state    <= rx_in ? BIT_IDLE : BIT_DATA;
				end else begin
					baud_cnt <= baud_cnt + 16'd1;
				end
				BIT_DATA: if (full_hit) begin
					baud_cnt <= '0;
					bit_cnt  <= bit_cnt + 3'd1;
					if (bit_cnt == 3'd7)
						state <= BIT_STOP;
				end else begin
					baud_cnt <= baud_cnt + 16'd1;
				end
				BIT_STOP: if (full_hit) begin
					baud_cnt    <= '0;
					state       <= BIT_IDLE;
					rx_byte_vld <= 1'b1;
					rx_byte_err <= ~rx_in;
				end else begin
					baud_cnt <= baud_cnt + 16'd1;
				end
				default: state <= BIT_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

/* source/uart_tx.sv */
// uart transmit bit engine
// 1 start bit, 8 data bits lsb first, 1 stop bit, no parity
`timescale 1ns/1ps
`default_nettype none

module uart_tx import uart_frame_pkg::*; (
	input  logic      sys_clk,
	input  logic      sys_rst_n,
	input  baud_div_t baud_div,
	input  logic      byte_start,
	input  char_t     byte_data,
	output logic      byte_idle,
	output logic      byte_done,
	output logic      uart_tx_line
);

	bit_state_e state;
	baud_div_t  baud_cnt;
	logic [2:0] bit_cnt;
	char_t      shift_reg;
	logic       bit_end;
	logic       shift_en;

	assign bit_end   = (baud_cnt == baud_div - 16'd1);
	assign shift_en  = bit_end && (state == BIT_START ||
		(state == BIT_DATA && bit_cnt != 3'd7));
	assign byte_idle = (state == BIT_IDLE);

	always_ff @(posedge sys_clk) begin
		if (byte_idle && byte_start)
			shift_reg <= byte_data;
		else if (shift_en)
			shift_reg <= {1'b0, shift_reg[7:1]};
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state        <= BIT_IDLE;
			baud_cnt     <= '0;
			bit_cnt      <= '0;
			byte_done    <= 1'b0;
			uart_tx_line <= 1'b1;
		end else begin
			byte_done <= 1'b0;
			if (byte_idle || bit_end)
				baud_cnt <= '0;
			else
				baud_cnt <= baud_cnt + 16'd1;
			case (state)
				BIT_IDLE: if (byte_start) begin
					state        <= BIT_START;
					uart_tx_line <= 1'b0;
				end
				BIT_START: if (bit_end) begin
					state        <= BIT_DATA;
					bit_cnt      <= '0;
					uart_tx_line <= shift_reg[0];
				end
				BIT_DATA: if (bit_end) begin
					bit_cnt <= bit_cnt + 3'd1;
					if (bit_cnt == 3'd7) begin
						state        <= BIT_STOP;
						uart_tx_line <= 1'b1;
					end else begin
						uart_tx_line <= shift_reg[0];
					end
				end
				BIT_STOP: if (bit_end) begin
					// done shows up right after the last stop-bit cycle
					state     <= BIT_IDLE;
					byte_done <= 1'b1;
				end
				default: state <= BIT_IDLE;
			endcase
		end
	end

	assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		byte_start |-> byte_idle);

endmodule

`default_nettype wire

/* uart_frame_top.f */
source/uart_frame_pkg.sv
source/uart_link_cfg.sv
source/uart_tx.sv
source/uart_rx.sv
source/frame_tx.sv
source/frame_rx.sv
source/uart_frame_top.sv
sim/tb_uart_frame_top.sv
